// ==== icache.f ====
hw/icache_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_refill.sv
hw/icache.sv
dv/icache_checker.sv
dv/tb_icache.sv

// ==== Makefile ====
TOP := tb_icache

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f icache.f --Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// ==== dv/tb_icache.sv ====
`timescale 1ns/1ns

module tb_icache;
    import icache_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int NUM_RANDOM   = 60;
    localparam int NUM_REQUESTS = 40 + NUM_RANDOM;
    // Request rise, four words after up to three idle cycles each, completion, handshake
    localparam int MAX_REQ_CYCLES  = 1 + BLOCK_WORDS * 4 + 1 + 3;
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * MAX_REQ_CYCLES + 100;

    logic        Clk;
    logic        rst_n;
    logic        read_enable;
    logic [31:0] read_address;
    logic [31:0] instruction;
    logic        ready;
    logic        busy;
    logic [31:0] mem_read_address;
    logic        mem_read_request;
    logic [31:0] mem_data;
    logic        mem_data_ready;
    logic [31:0] rand_addr [NUM_RANDOM];
    int          seed = 36181;
    int          test_num = 0;
    int          prev_checks = 0;
    int          prev_errors = 0;
    int          check_count;
    int          error_count;

    icache u_dut (.*);

    icache_checker u_chk (.*);

    initial begin
        Clk = 1'b0;
        forever #(CLK_PERIOD / 2) Clk = ~Clk;
    end

    function automatic logic [31:0] memory_word(logic [31:0] addr);
        return (addr ^ 32'h5A3C_96E1) + {addr[24:0], addr[31:25]};
    endfunction

    function automatic logic [31:0] make_addr(int tag, int set_idx, int word);
        cache_addr_t a;
        a.tag      = TAG_BITS'(tag);
        a.set_idx  = SET_BITS'(set_idx);
        a.word     = WORD_OFF_BITS'(word);
        a.byte_off = '0;
        return a;
    endfunction

    // SDRAM burst model, 0 to 3 idle cycles before each word
    initial begin
        logic [31:0] base;
        int          gap;
        mem_data       <= '0;
        mem_data_ready <= 1'b0;
        forever begin
            @(negedge Clk);
            if (rst_n && mem_read_request) begin
                base = mem_read_address;
                for (int i = 0; i < BLOCK_WORDS; i++) begin
                    gap = {$random(seed)} % 4;
                    repeat (gap) begin
                        @(posedge Clk);
                        mem_data_ready <= 1'b0;
                    end
                    @(posedge Clk);
                    mem_data       <= memory_word(base + 32'(i * 4));
                    mem_data_ready <= 1'b1;
                end
                @(posedge Clk);
                mem_data_ready <= 1'b0;
            end
        end
    end

    // Core side fetch, request held until ready
    task automatic fetch(input logic [31:0] addr);
        @(posedge Clk);
        read_enable  <= 1'b1;
        read_address <= addr;
        do begin
            @(negedge Clk);
        end while (!ready);
        @(posedge Clk);
        read_enable <= 1'b0;
    endtask

    task automatic report_test(input string name);
        test_num++;
        $display("test %0d %-15s %0d checks, %0d errors", test_num, name,
                 check_count - prev_checks, error_count - prev_errors);
        prev_checks = check_count;
        prev_errors = error_count;
    endtask

    initial begin
        rst_n        <= 1'b0;
        read_enable  <= 1'b0;
        read_address <= '0;
        // Drawn before the memory model starts using the seed
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rand_addr[i] = ({$random(seed)} % 256) * 4;
        end
        repeat (5) @(posedge Clk);
        rst_n <= 1'b1;

        for (int s = 0; s < 4; s++) begin
            fetch(make_addr(1, s, s));
            fetch(make_addr(2, s, 3 - s));
        end
        report_test("cold misses");

        for (int w = 0; w < BLOCK_WORDS; w++) begin
            fetch(make_addr(1, 0, w));
            fetch(make_addr(2, 1, w));
        end
        report_test("hit latency");

        // Misses on non-zero offsets, then the whole block
        fetch(make_addr(3, 4, 2));
        for (int w = 0; w < BLOCK_WORDS; w++) fetch(make_addr(3, 4, w));
        fetch(make_addr(4, 5, 3));
        for (int w = 0; w < BLOCK_WORDS; w++) fetch(make_addr(4, 5, w));
        report_test("critical word");

        // Tag 14 evicts way 0, then 10 and 11 evict ways 1 and 2
        for (int t = 10; t < 15; t++) fetch(make_addr(t, 7, 0));
        fetch(make_addr(12, 7, 1));
        fetch(make_addr(10, 7, 2));
        fetch(make_addr(11, 7, 3));
        fetch(make_addr(13, 7, 0));
        fetch(make_addr(14, 7, 1));
        report_test("replacement");

        for (int i = 0; i < NUM_RANDOM; i++) fetch(rand_addr[i]);
        report_test("random traffic");

        fetch(make_addr(3, 4, 1));
        @(posedge Clk);
        rst_n <= 1'b0;
        repeat (5) @(posedge Clk);
        rst_n <= 1'b1;
        fetch(make_addr(3, 4, 1));
        report_test("reset");

        $display("total: %0d tests, %0d checks, %0d errors", test_num, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, a fetch never completed", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== dv/icache_checker.sv ====
`timescale 1ns/1ns

module icache_checker (
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        read_enable,
    input  logic [31:0] read_address,
    input  logic [31:0] instruction,
    input  logic        ready,
    input  logic        busy,
    input  logic [31:0] mem_read_address,
    input  logic        mem_read_request,
    output int          check_count,
    output int          error_count
);
    import icache_pkg::*;

    // Reference cache state
    logic [TAG_BITS-1:0] model_tag [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] model_valid [NUM_SETS];
    logic [WAY_BITS-1:0] model_ptr [NUM_SETS];

    cache_addr_t req;
    logic        pending = 1'b0;
    logic        exp_hit = 1'b0;
    logic        req_seen = 1'b0;
    logic        reset_edge_seen = 1'b0;
    int          cycle = 0;
    int          accept_cycle = 0;
    int          age;
    int          checks = 0;
    int          errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    // Memory content is the address XOR a constant plus the address rotated left by 7
    function automatic logic [31:0] expected_word(logic [31:0] addr);
        return (addr ^ 32'h5A3C_96E1) + {addr[24:0], addr[31:25]};
    endfunction

    function automatic bit should_hit(cache_addr_t a);
        bit found;
        found = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[a.set_idx][w] && model_tag[a.set_idx][w] == a.tag) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Full set takes the pointer's way, else the lowest free way
    task automatic model_fill(cache_addr_t a);
        logic [WAY_BITS-1:0] victim;
        if (&model_valid[a.set_idx]) begin
            victim = model_ptr[a.set_idx];
            model_ptr[a.set_idx] = victim + 1'b1;
        end else begin
            victim = '0;
            while (model_valid[a.set_idx][victim]) begin
                victim++;
            end
        end
        model_valid[a.set_idx][victim] = 1'b1;
        model_tag[a.set_idx][victim] = a.tag;
    endtask

    task automatic compare_hex(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got 0x%08h expected 0x%08h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic expect_true(bit cond, string what);
        checks++;
        if (!cond) begin
            errors++;
            $display("Check failed at %0t ns: %s", $time, what);
        end
    endtask

    // Sampled mid-cycle away from the driving edge
    always @(negedge Clk) begin
        if (!rst_n) begin
            if (reset_edge_seen) begin
                expect_true(ready === 1'b0 && busy === 1'b0 && mem_read_request === 1'b0,
                            "ready, busy or mem_read_request not low in reset");
            end
            reset_edge_seen = 1'b1;
            pending = 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                model_valid[s] = '0;
                model_ptr[s] = '0;
            end
        end else begin
            reset_edge_seen = 1'b0;
            cycle++;
            if (pending) begin
                age = cycle - accept_cycle;
                if (mem_read_request && !req_seen) begin
                    req_seen = 1'b1;
                    expect_true(!exp_hit, "memory request issued for an access that should hit");
                    expect_true(age == 1, "mem_read_request did not rise one cycle after the miss");
                    compare_hex("mem_read_address", mem_read_address,
                                32'(req) & ~32'(BLOCK_WORDS * 4 - 1));
                end
                if (ready) begin
                    if (!exp_hit) begin
                        expect_true(req_seen, "miss answered without a memory request");
                    end
                    expect_true(!busy, "busy still high in the ready cycle");
                    compare_hex("instruction", instruction, expected_word(req));
                    pending = 1'b0;
                end else if (exp_hit) begin
                    expect_true(1'b0, "no ready one cycle after a hit");
                    pending = 1'b0;
                end else begin
                    expect_true(busy === 1'b1, "busy low while a miss is outstanding");
                end
            end else begin
                if (ready) begin
                    expect_true(1'b0, "ready pulsed with no request outstanding");
                end
                if (read_enable) begin
                    req = cache_addr_t'(read_address);
                    exp_hit = should_hit(req);
                    if (!exp_hit) begin
                        model_fill(req);
                    end
                    req_seen = 1'b0;
                    accept_cycle = cycle;
                    pending = 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/icache.sv ====
`timescale 1ns/1ns

module icache (
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        read_enable,
    input  logic [31:0] read_address,
    output logic [31:0] instruction,
    output logic        ready,
    output logic        busy,
    output logic [31:0] mem_read_address,
    output logic        mem_read_request,
    input  logic [31:0] mem_data,
    input  logic        mem_data_ready
);
    import icache_pkg::*;

    cache_addr_t          req_addr;
    logic                 hit;
    logic [WAY_BITS-1:0]  hit_way;
    logic [WAY_BITS-1:0]  victim_way;
    logic                 accept;
    logic                 hit_accept;
    logic                 miss_start;
    logic                 hit_ready_q;
    logic                 miss_pending_q;
    lookup_t              rd_req;
    logic [WORD_BITS-1:0] read_word;
    logic [WORD_BITS-1:0] critical_word;
    refill_wr_t           refill;
    logic                 refill_valid;
    logic                 refill_done;

    assign req_addr = cache_addr_t'(read_address);

    // Core holds the request through its ready cycle, so skip that one
    assign accept     = read_enable && !miss_pending_q && !hit_ready_q;
    assign hit_accept = accept && hit;
    assign miss_start = accept && !hit;

    assign rd_req = '{set_idx: req_addr.set_idx, way: hit_way, word: req_addr.word};

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            hit_ready_q    <= 1'b0;
            miss_pending_q <= 1'b0;
        end else begin
            hit_ready_q <= hit_accept;
            if (miss_start) begin
                miss_pending_q <= 1'b1;
            end else if (refill_done) begin
                miss_pending_q <= 1'b0;
            end
        end
    end

    assign ready       = hit_ready_q || refill_done;
    assign busy        = miss_pending_q && !refill_done;
    assign instruction = refill_done ? critical_word : read_word;

    icache_tag_array u_tags (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .lookup_set   (req_addr.set_idx),
        .lookup_tag   (req_addr.tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .refill       (refill),
        .refill_valid (refill_valid)
    );

    icache_data_array u_data (
        .Clk          (Clk),
        .read_req     (rd_req),
        .read_en      (hit_accept),
        .read_word    (read_word),
        .refill       (refill),
        .refill_valid (refill_valid)
    );

    icache_refill u_refill (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .start            (miss_start),
        .miss_addr        (req_addr),
        .victim_way       (victim_way),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data         (mem_data),
        .mem_data_ready   (mem_data_ready),
        .refill           (refill),
        .refill_valid     (refill_valid),
        .critical_word    (critical_word),
        .done             (refill_done)
    );

    // One answer per request
    assert property (@(posedge Clk) disable iff (!rst_n) ready |=> !ready);

endmodule

// ==== hw/icache_refill.sv ====
`timescale 1ns/1ns

module icache_refill (
    input  logic                             Clk,
    input  logic                             rst_n,
    input  logic                             start,
    input  icache_pkg::cache_addr_t          miss_addr,
    input  logic [icache_pkg::WAY_BITS-1:0]  victim_way,
    output logic [31:0]                      mem_read_address,
    output logic                             mem_read_request,
    input  logic [31:0]                      mem_data,
    input  logic                             mem_data_ready,
    output icache_pkg::refill_wr_t           refill,
    output logic                             refill_valid,
    output logic [icache_pkg::WORD_BITS-1:0] critical_word,
    output logic                             done
);
    import icache_pkg::*;

    cache_addr_t              miss_q;
    logic [WAY_BITS-1:0]      way_q;
    logic [WORD_OFF_BITS-1:0] word_cnt;
    block_t                   block_q;
    logic                     fill_q;
    logic                     word_in;
    logic                     last_word;

    assign word_in   = mem_read_request && mem_data_ready;
    assign last_word = word_in && (word_cnt == WORD_OFF_BITS'(BLOCK_WORDS - 1));

    // Request stays up for the whole burst
    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            mem_read_request <= 1'b0;
            word_cnt         <= '0;
            fill_q           <= 1'b0;
        end else begin
            fill_q <= last_word;
            if (start) begin
                mem_read_request <= 1'b1;
                word_cnt         <= '0;
            end else if (word_in) begin
                word_cnt <= word_cnt + 1'b1;
                if (last_word) begin
                    mem_read_request <= 1'b0;
                end
            end
        end
    end

    // Miss context and burst buffer
    always_ff @(posedge Clk) begin
        if (start) begin
            miss_q <= miss_addr;
            way_q  <= victim_way;
        end
        if (word_in) begin
            block_q[word_cnt] <= mem_data;
        end
    end

    // Burst always starts at word 0 of the line
    assign mem_read_address = {miss_q.tag, miss_q.set_idx,
                               {(WORD_OFF_BITS + BYTE_OFF_BITS){1'b0}}};

    assign refill = '{set_idx: miss_q.set_idx,
                      way:     way_q,
                      tag:     miss_q.tag,
                      data:    block_q};

    assign refill_valid  = fill_q;
    assign done          = fill_q;
    assign critical_word = block_q[miss_q.word];

    // Request must not drop early
    assert property (@(posedge Clk) disable iff (!rst_n)
        $fell(mem_read_request) |-> $past(last_word));

    // Top only starts a miss when no burst is outstanding
    assert property (@(posedge Clk) disable iff (!rst_n)
        start |-> !mem_read_request && !fill_q);

endmodule

// ==== hw/icache_data_array.sv ====
`timescale 1ns/1ns

module icache_data_array (
    input  logic                             Clk,
    input  icache_pkg::lookup_t              read_req,
    input  logic                             read_en,
    output logic [icache_pkg::WORD_BITS-1:0] read_word,
    input  icache_pkg::refill_wr_t           refill,
    input  logic                             refill_valid
);
    import icache_pkg::*;

    block_t blocks [NUM_SETS][NUM_WAYS];

    // Whole line lands in one write
    always_ff @(posedge Clk) begin
        if (refill_valid) begin
            blocks[refill.set_idx][refill.way] <= refill.data;
        end
    end

    // Registered word read, one cycle behind read_en
    always_ff @(posedge Clk) begin
        if (read_en) begin
            read_word <= blocks[read_req.set_idx][read_req.way][read_req.word];
        end
    end

endmodule

// ==== hw/icache_tag_array.sv ====
`timescale 1ns/1ns

module icache_tag_array (
    input  logic                            Clk,
    input  logic                            rst_n,
    input  logic [icache_pkg::SET_BITS-1:0] lookup_set,
    input  logic [icache_pkg::TAG_BITS-1:0] lookup_tag,
    output logic                            hit,
    output logic [icache_pkg::WAY_BITS-1:0] hit_way,
    output logic [icache_pkg::WAY_BITS-1:0] victim_way,
    input  icache_pkg::refill_wr_t          refill,
    input  logic                            refill_valid
);
    import icache_pkg::*;

    logic [TAG_BITS-1:0] tags [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid [NUM_SETS];
    logic [WAY_BITS-1:0] rr_ptr [NUM_SETS];
    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] set_valid;

    assign set_valid = valid[lookup_set];

    // Parallel compare across all ways of the indexed set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = set_valid[w] && (tags[lookup_set][w] == lookup_tag);
            if (way_hit[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit = |way_hit;

    // Lowest invalid way wins, otherwise the set's pointer
    always_comb begin
        victim_way = rr_ptr[lookup_set];
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                victim_way = WAY_BITS'(w);
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (refill_valid) begin
            valid[refill.set_idx][refill.way] <= 1'b1;
            // Pointer only moves once the set is full
            if (&valid[refill.set_idx]) begin
                rr_ptr[refill.set_idx] <= refill.way + 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (refill_valid) begin
            tags[refill.set_idx][refill.way] <= refill.tag;
        end
    end

    // A line is never loaded into two ways of one set
    assert property (@(posedge Clk) disable iff (!rst_n) $onehot0(way_hit));

endmodule

// ==== hw/icache_pkg.sv ====
package icache_pkg;

    // Cache geometry
    localparam int NUM_SETS    = 8;
    localparam int NUM_WAYS    = 4;
    localparam int BLOCK_WORDS = 4;
    localparam int WORD_BITS   = 32;

    // Address field widths
    localparam int BYTE_OFF_BITS = 2;
    localparam int WORD_OFF_BITS = $clog2(BLOCK_WORDS);
    localparam int SET_BITS      = $clog2(NUM_SETS);
    localparam int WAY_BITS      = $clog2(NUM_WAYS);
    localparam int TAG_BITS      = 32 - SET_BITS - WORD_OFF_BITS - BYTE_OFF_BITS;

    // One cache line, word 0 in the low slice
    typedef logic [BLOCK_WORDS-1:0][WORD_BITS-1:0] block_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]      tag;
        logic [SET_BITS-1:0]      set_idx;
        logic [WORD_OFF_BITS-1:0] word;
        logic [BYTE_OFF_BITS-1:0] byte_off;
    } cache_addr_t;

    // Whole-line write issued once per miss
    typedef struct packed {
        logic [SET_BITS-1:0] set_idx;
        logic [WAY_BITS-1:0] way;
        logic [TAG_BITS-1:0] tag;
        block_t              data;
    } refill_wr_t;

    typedef struct packed {
        logic [SET_BITS-1:0]      set_idx;
        logic [WAY_BITS-1:0]      way;
        logic [WORD_OFF_BITS-1:0] word;
    } lookup_t;

endpackage
